/* rtl/eeprom_pkg.sv */
package eeprom_pkg;

    // control byte is {DEV_CODE, page, rw}
    localparam logic [3:0] DEV_CODE = 4'b1010;
    localparam logic       RW_WRITE = 1'b0;
    localparam logic       RW_READ  = 1'b1;

    typedef struct packed {
        logic [2:0] page;    // goes into the control byte
        logic [7:0] offset;  // sent as word address
    } eeprom_addr_s;

    typedef union packed {
        logic [10:0]  raw;
        eeprom_addr_s f;
    } eeprom_addr_u;

    typedef struct packed {
        logic         wr;
        eeprom_addr_u addr;
        logic [7:0]   wdata;
    } eeprom_req_t;

    // start doubles as repeated start
    typedef enum logic [1:0] {
        OP_START,
        OP_WRITE,
        OP_READ,
        OP_STOP
    } bus_op_e;

    typedef struct packed {
        bus_op_e    op;
        logic [7:0] data;
        logic       ack;  // level driven after a read byte, 1 = nack
    } bus_cmd_t;

endpackage

/* rtl/eeprom_req_regs.sv */
`timescale 1ns/100ps

module eeprom_req_regs
    import eeprom_pkg::*;
(
    input  logic        CLK,
    input  logic        RESET,
    input  logic        wr,
    input  logic        rd,
    input  logic [10:0] addr,
    input  logic [7:0]  wdata,
    output logic        start,
    output eeprom_req_t req,
    input  logic        done,
    input  logic        nack_seen,
    input  logic [7:0]  seq_rdata,
    output logic        busy,
    output logic        ack,
    output logic        nack_err,
    output logic [7:0]  rdata
);

    logic accept;

    assign accept = !busy && (wr || rd); // strobes while busy are dropped

    always_ff @(posedge CLK) begin
        if (RESET) begin
            start    <= 1'b0;
            busy     <= 1'b0;
            ack      <= 1'b0;
            nack_err <= 1'b0;
        end else begin
            start <= accept;
            ack   <= done;
            if (accept) begin
                busy <= 1'b1;
            end else if (done) begin
                busy     <= 1'b0;
                nack_err <= nack_seen;
            end
        end
    end

    // request and read data
    always_ff @(posedge CLK) begin
        if (accept) begin
            req.wr       <= wr; // write wins over read
            req.addr.raw <= addr;
            req.wdata    <= wdata;
        end
        if (done && !nack_seen && !req.wr)
            rdata <= seq_rdata;
    end

    a_ack_after_busy: assert property (@(posedge CLK) disable iff (RESET)
        ack |-> $past(busy));

endmodule

/* rtl/eeprom_seq_ctrl.sv */
`timescale 1ns/100ps

module eeprom_seq_ctrl
    import eeprom_pkg::*;
(
    input  logic        CLK,
    input  logic        RESET,
    input  logic        start,
    input  eeprom_req_t req,
    output logic        done,
    output logic        nack_seen,
    output logic [7:0]  seq_rdata,
    output logic        cmd_valid,
    output bus_cmd_t    cmd,
    input  logic        op_done,
    input  logic [7:0]  rx_byte,
    input  logic        rx_ack
);

    localparam int NS        = 9;
    localparam int S_IDLE    = 0;
    localparam int S_START   = 1;
    localparam int S_CTRL_WR = 2;
    localparam int S_ADDR_WR = 3;
    localparam int S_DATA_WR = 4;
    localparam int S_RESTART = 5;
    localparam int S_CTRL_RD = 6;
    localparam int S_DATA_RD = 7;
    localparam int S_STOP    = 8;

    logic [NS-1:0] state;
    logic [NS-1:0] state_nxt;
    logic          tx_state;

    function automatic logic [NS-1:0] oh(input int idx);
        return NS'(1) << idx;
    endfunction

    // states that send a byte and expect the slave ack
    assign tx_state = state[S_CTRL_WR] | state[S_ADDR_WR] | state[S_DATA_WR] | state[S_CTRL_RD];

    always_comb begin
        state_nxt = state;
        case (1'b1)
            state[S_IDLE]:    if (start) state_nxt = oh(S_START);
            state[S_START]:   if (op_done) state_nxt = oh(S_CTRL_WR);
            state[S_CTRL_WR]: if (op_done) state_nxt = rx_ack ? oh(S_STOP) : oh(S_ADDR_WR);
            state[S_ADDR_WR]: begin
                if (op_done) begin
                    if (rx_ack)
                        state_nxt = oh(S_STOP);
                    else if (req.wr)
                        state_nxt = oh(S_DATA_WR);
                    else
                        state_nxt = oh(S_RESTART);
                end
            end
            state[S_DATA_WR]: if (op_done) state_nxt = oh(S_STOP);
            state[S_RESTART]: if (op_done) state_nxt = oh(S_CTRL_RD);
            state[S_CTRL_RD]: if (op_done) state_nxt = rx_ack ? oh(S_STOP) : oh(S_DATA_RD);
            state[S_DATA_RD]: if (op_done) state_nxt = oh(S_STOP);
            state[S_STOP]:    if (op_done) state_nxt = oh(S_IDLE);
            default:          state_nxt = oh(S_IDLE);
        endcase
    end

    // command follows the state, cmd_valid marks its first cycle
    always_comb begin
        cmd.op   = OP_STOP;
        cmd.data = 8'h00;
        cmd.ack  = 1'b1;
        case (1'b1)
            state[S_START], state[S_RESTART]: cmd.op = OP_START;
            state[S_CTRL_WR]: begin
                cmd.op   = OP_WRITE;
                cmd.data = {DEV_CODE, req.addr.f.page, RW_WRITE};
            end
            state[S_ADDR_WR]: begin
                cmd.op   = OP_WRITE;
                cmd.data = req.addr.f.offset;
            end
            state[S_DATA_WR]: begin
                cmd.op   = OP_WRITE;
                cmd.data = req.wdata;
            end
            state[S_CTRL_RD]: begin
                cmd.op   = OP_WRITE;
                cmd.data = {DEV_CODE, req.addr.f.page, RW_READ};
            end
            state[S_DATA_RD]: cmd.op = OP_READ; // single byte, ends with nack
            default: ;
        endcase
    end

    always_ff @(posedge CLK) begin
        if (RESET) begin
            state     <= oh(S_IDLE);
            cmd_valid <= 1'b0;
            done      <= 1'b0;
            nack_seen <= 1'b0;
        end else begin
            state     <= state_nxt;
            cmd_valid <= (state_nxt != state) && !state_nxt[S_IDLE];
            done      <= op_done && state[S_STOP];
            if (start)
                nack_seen <= 1'b0;
            else if (op_done && tx_state && rx_ack)
                nack_seen <= 1'b1;
        end
    end

    always_ff @(posedge CLK) begin
        if (op_done && state[S_DATA_RD])
            seq_rdata <= rx_byte;
    end

    a_state_onehot: assert property (@(posedge CLK) disable iff (RESET)
        $onehot(state));

endmodule

/* rtl/eeprom_bit_engine.sv */
`timescale 1ns/100ps

module eeprom_bit_engine
    import eeprom_pkg::*;
#(
    parameter int SCL_HALF = 4
) (
    input  logic       CLK,
    input  logic       RESET,
    input  logic       cmd_valid,
    input  bus_cmd_t   cmd,
    output logic       op_done,
    output logic [7:0] rx_byte,
    output logic       rx_ack,
    output logic       scl,
    output logic       sda_oe,
    input  logic       sda_in
);

    localparam int             CW   = $clog2(SCL_HALF);
    localparam logic [CW-1:0] MID  = CW'(SCL_HALF / 2);
    localparam logic [CW-1:0] LAST = CW'(SCL_HALF - 1);

    logic          active;
    logic [CW-1:0] cnt;     // clk count within a half period
    logic [4:0]    half;    // even = scl low, odd = scl high
    logic [3:0]    bit_idx;
    logic [4:0]    last_half;
    logic          edge_op;
    logic          sda_nxt;
    bus_op_e       op_r;
    logic [7:0]    tx_sr;
    logic          ack_r;

    assign bit_idx   = half[4:1];
    assign edge_op   = (op_r == OP_START) || (op_r == OP_STOP);
    assign last_half = edge_op ? 5'd1 : 5'd17; // 2 halves or 9 scl periods

    // sda level at mid of the current half
    always_comb begin
        sda_nxt = sda_oe;
        case (op_r)
            OP_START: sda_nxt = half[0];  // release low, pull while scl high
            OP_STOP:  sda_nxt = !half[0];
            OP_WRITE: if (!half[0]) sda_nxt = (bit_idx < 4'd8) ? !tx_sr[7] : 1'b0;
            OP_READ:  if (!half[0]) sda_nxt = (bit_idx < 4'd8) ? 1'b0 : !ack_r;
            default: ;
        endcase
    end

    always_ff @(posedge CLK) begin
        if (RESET) begin
            active  <= 1'b0;
            op_done <= 1'b0;
            scl     <= 1'b1;
            sda_oe  <= 1'b0;
            cnt     <= '0;
            half    <= '0;
        end else begin
            op_done <= 1'b0;
            if (cmd_valid && !active) begin
                active <= 1'b1;
                cnt    <= '0;
                half   <= '0;
            end else if (active) begin
                if (cnt == '0)
                    scl <= half[0];
                if (cnt == MID)
                    sda_oe <= sda_nxt;
                if (cnt == LAST) begin
                    cnt <= '0;
                    if (half == last_half) begin
                        active  <= 1'b0;
                        op_done <= 1'b1;
                    end else begin
                        half <= half + 5'd1;
                    end
                end else begin
                    cnt <= cnt + 1'b1;
                end
            end
        end
    end

    // shift registers, msb first
    always_ff @(posedge CLK) begin
        if (cmd_valid && !active) begin
            op_r  <= cmd.op;
            tx_sr <= cmd.data;
            ack_r <= cmd.ack;
        end else if (active && cnt == MID && !edge_op && bit_idx < 4'd8) begin
            if (!half[0])
                tx_sr <= {tx_sr[6:0], 1'b0};
            else
                rx_byte <= {rx_byte[6:0], sda_in}; // mid of scl high
        end
        if (active && cnt == MID && !edge_op && half[0] && bit_idx == 4'd8)
            rx_ack <= sda_in;
    end

    a_no_cmd_busy: assert property (@(posedge CLK) disable iff (RESET)
        cmd_valid |-> !active);

    // data only moves while scl is low, start and stop excepted
    a_sda_stable: assert property (@(posedge CLK) disable iff (RESET)
        (scl && $past(scl) && !$past(active && edge_op)) |-> $stable(sda_oe));

endmodule

/* rtl/eeprom_wr_top.sv */
`timescale 1ns/100ps

module eeprom_wr_top
    import eeprom_pkg::*;
#(
    parameter int SCL_HALF = 4
) (
    input  logic        CLK,
    input  logic        RESET,
    input  logic        wr,
    input  logic        rd,
    input  logic [10:0] addr,
    input  logic [7:0]  wdata,
    output logic        busy,
    output logic        ack,
    output logic        nack_err,
    output logic [7:0]  rdata,
    output logic        scl,
    output logic        sda_oe,
    input  logic        sda_in
);

    logic        start;
    eeprom_req_t req;
    logic        done;
    logic        nack_seen;
    logic [7:0]  seq_rdata;
    logic        cmd_valid;
    bus_cmd_t    cmd;
    logic        op_done;
    logic [7:0]  rx_byte;
    logic        rx_ack;

    eeprom_req_regs eeprom_req_regs_i (
        .CLK       (CLK),
        .RESET     (RESET),
        .wr        (wr),
        .rd        (rd),
        .addr      (addr),
        .wdata     (wdata),
        .start     (start),
        .req       (req),
        .done      (done),
        .nack_seen (nack_seen),
        .seq_rdata (seq_rdata),
        .busy      (busy),
        .ack       (ack),
        .nack_err  (nack_err),
        .rdata     (rdata)
    );

    eeprom_seq_ctrl eeprom_seq_ctrl_i (
        .CLK       (CLK),
        .RESET     (RESET),
        .start     (start),
        .req       (req),
        .done      (done),
        .nack_seen (nack_seen),
        .seq_rdata (seq_rdata),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .op_done   (op_done),
        .rx_byte   (rx_byte),
        .rx_ack    (rx_ack)
    );

    eeprom_bit_engine #(
        .SCL_HALF (SCL_HALF)
    ) eeprom_bit_engine_i (
        .CLK       (CLK),
        .RESET     (RESET),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .op_done   (op_done),
        .rx_byte   (rx_byte),
        .rx_ack    (rx_ack),
        .scl       (scl),
        .sda_oe    (sda_oe),
        .sda_in    (sda_in)
    );

endmodule

/* sim/eeprom_model.sv */
`timescale 1ns/100ps

module eeprom_model (
    input  logic scl,
    input  logic sda,
    input  logic no_ack,
    output logic pull
);

    typedef enum logic [2:0] {
        M_IDLE,
        M_CTRL,
        M_ADDR,
        M_DATA,
        M_TXD
    } phase_e;

    phase_e      phase;
    phase_e      nxt_phase;
    logic [3:0]  bit_cnt;
    logic [7:0]  sr;
    logic [7:0]  tx_sr;
    logic [2:0]  page;
    logic [10:0] ptr;
    logic        scl_q;
    logic        sda_q;
    logic [7:0]  mem [0:2047];

    initial begin
        pull      = 1'b0;
        phase     = M_IDLE;
        nxt_phase = M_IDLE;
        bit_cnt   = 4'd0;
        sr        = 8'h00;
        page      = 3'd0;
        ptr       = 11'd0;
        scl_q     = 1'b1;
        sda_q     = 1'b1;
        for (int i = 0; i < 2048; i++) begin
            mem[i] = 8'hFF; // erased
        end
    end

    always @(scl or sda) begin
        if (scl && scl_q && sda_q && !sda) begin // start or repeated start
            phase   = M_CTRL;
            bit_cnt = 4'd0;
            pull    = 1'b0;
        end else if (scl && scl_q && !sda_q && sda) begin // stop
            phase = M_IDLE;
            pull  = 1'b0;
        end else if (scl && !scl_q && phase != M_IDLE) begin
            if (bit_cnt < 4'd8 && phase != M_TXD)
                sr = {sr[6:0], sda};
            if (bit_cnt == 4'd8 && phase == M_TXD && sda)
                nxt_phase = M_IDLE; // master nack ends the read
            bit_cnt = bit_cnt + 4'd1;
        end else if (!scl && scl_q && phase != M_IDLE) begin
            if (bit_cnt == 4'd9) begin // ack clock over
                pull    = 1'b0;
                bit_cnt = 4'd0;
                phase   = nxt_phase;
                if (phase == M_TXD) begin
                    tx_sr = mem[ptr];
                    pull  = !tx_sr[7];
                end
            end else if (phase == M_TXD) begin
                pull = (bit_cnt < 4'd8) ? !tx_sr[3'd7 - bit_cnt[2:0]] : 1'b0;
            end else if (bit_cnt == 4'd8) begin
                case (phase)
                    M_CTRL: begin
                        if (sr[7:4] == 4'b1010 && !no_ack) begin
                            page = sr[3:1];
                            pull = 1'b1;
                            if (sr[0]) begin
                                ptr       = {sr[3:1], ptr[7:0]};
                                nxt_phase = M_TXD;
                            end else begin
                                nxt_phase = M_ADDR;
                            end
                        end else begin
                            phase = M_IDLE; // not for us
                        end
                    end
                    M_ADDR: begin
                        ptr       = {page, sr};
                        pull      = 1'b1;
                        nxt_phase = M_DATA;
                    end
                    M_DATA: begin
                        mem[ptr]  = sr;
                        pull      = 1'b1;
                        nxt_phase = M_IDLE;
                    end
                    default: ;
                endcase
            end
        end
        scl_q = scl;
        sda_q = sda;
    end

endmodule

/* sim/tb_eeprom_wr.sv */
`timescale 1ns/100ps

module tb_eeprom_wr;

    localparam int SCL_HALF = 4;
    localparam int MAX_WAIT = 120 * 2 * SCL_HALF;

    logic        CLK;
    logic        RESET;
    logic        wr;
    logic        rd;
    logic [10:0] addr;
    logic [7:0]  wdata;
    logic        busy;
    logic        ack;
    logic        nack_err;
    logic [7:0]  rdata;
    logic        scl;
    logic        sda_oe;
    logic        sda;
    logic        no_ack;
    logic        model_pull;

    logic [31:0] lfsr = 32'hf25d;
    int          err_cnt = 0;
    int          timeout_cnt = 0;
    logic [7:0]  ref_mem [0:2047];
    logic        written [0:2047];
    logic [7:0]  last_rdata;
    logic [7:0]  exp_rdata_q [$];
    logic        exp_nack_q [$];
    logic [10:0] addr_list [20];

    assign sda = !(sda_oe || model_pull); // wired-AND

    eeprom_wr_top #(
        .SCL_HALF (SCL_HALF)
    ) eeprom_wr_top_i (
        .CLK      (CLK),
        .RESET    (RESET),
        .wr       (wr),
        .rd       (rd),
        .addr     (addr),
        .wdata    (wdata),
        .busy     (busy),
        .ack      (ack),
        .nack_err (nack_err),
        .rdata    (rdata),
        .scl      (scl),
        .sda_oe   (sda_oe),
        .sda_in   (sda)
    );

    eeprom_model eeprom_model_i (
        .scl    (scl),
        .sda    (sda),
        .no_ack (no_ack),
        .pull   (model_pull)
    );

    always #2 CLK = ~CLK;

    function automatic logic [31:0] next_lfsr(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = next_lfsr(lfsr);
            val  = {val[30:0], lfsr[0]};
        end
    endtask

    // last byte written to the address, erased value otherwise
    function automatic logic [7:0] expected_byte(input logic [10:0] a);
        return written[a] ? ref_mem[a] : 8'hFF;
    endfunction

    task automatic compare(input logic [31:0] got, input logic [31:0] exp, input string msg);
        if (got !== exp) begin
            err_cnt++;
            $display("[ERROR] %0t ns: %s got %h expected %h", $time, msg, got, exp);
        end
    endtask

    task automatic wait_ack();
        int n;
        n = 0;
        do begin
            @(negedge CLK);
            n++;
        end while (!ack && n < MAX_WAIT);
        if (!ack) begin
            timeout_cnt++;
            $display("timeout at %0t ns: no completion pulse after a request", $time);
        end
    endtask

    task automatic issue(input logic is_wr, input logic [10:0] a, input logic [7:0] d);
        @(posedge CLK);
        wr    <= is_wr;
        rd    <= !is_wr;
        addr  <= a;
        wdata <= d;
        @(posedge CLK);
        wr    <= 1'b0;
        rd    <= 1'b0;
    endtask

    task automatic write_byte(input logic [10:0] a, input logic [7:0] d);
        if (no_ack) begin
            exp_nack_q.push_back(1'b1);
        end else begin
            ref_mem[a] = d;
            written[a] = 1'b1;
            exp_nack_q.push_back(1'b0);
        end
        exp_rdata_q.push_back(last_rdata);
        issue(1'b1, a, d);
        wait_ack();
    endtask

    task automatic read_byte(input logic [10:0] a);
        last_rdata = expected_byte(a);
        exp_nack_q.push_back(1'b0);
        exp_rdata_q.push_back(last_rdata);
        issue(1'b0, a, 8'h00);
        wait_ack();
    endtask

    // compare process for every completion pulse
    always @(negedge CLK) begin
        if (!RESET && ack) begin
            if (exp_nack_q.size() == 0) begin
                err_cnt++;
                $display("completion pulse at %0t ns without a pending request", $time);
            end else begin
                compare(32'(nack_err), 32'(exp_nack_q.pop_front()), "nack_err");
                compare(32'(rdata), 32'(exp_rdata_q.pop_front()), "rdata");
                compare(32'(busy), 32'd0, "busy at completion");
            end
        end
    end

    initial begin
        logic [31:0] r;
        logic [10:0] a;
        logic [10:0] b;
        CLK    = 1'b0;
        RESET  = 1'b1;
        wr     = 1'b0;
        rd     = 1'b0;
        addr   = '0;
        wdata  = '0;
        no_ack = 1'b0;
        for (int i = 0; i < 2048; i++) begin
            written[i] = 1'b0;
        end
        repeat (4) @(posedge CLK);
        RESET <= 1'b0;
        @(negedge CLK);
        compare(32'(scl), 32'd1, "scl after reset");
        compare(32'(sda_oe), 32'd0, "sda_oe after reset");
        compare(32'(busy), 32'd0, "busy after reset");
        compare(32'(ack), 32'd0, "ack after reset");

        read_byte(11'h2a5); // erased before the first write
        write_byte(11'h2a5, 8'h3c); // write then read
        read_byte(11'h2a5);

        for (int i = 0; i < 20; i++) begin
            take_bits(8, r);
            addr_list[i] = {i[2:0], r[7:0]}; // every page
            take_bits(8, r);
            write_byte(addr_list[i], r[7:0]);
        end
        for (int i = 0; i < 20; i++) begin
            read_byte(addr_list[(i * 7) % 20]);
        end
        do begin
            take_bits(11, r);
            a = r[10:0];
        end while (written[a]);
        read_byte(a);

        // strobes while busy are dropped
        do begin
            take_bits(11, r);
            b = r[10:0];
        end while (written[b] || b == 11'h0f0);
        exp_nack_q.push_back(1'b0);
        exp_rdata_q.push_back(last_rdata);
        ref_mem[11'h0f0] = 8'h5a;
        written[11'h0f0] = 1'b1;
        issue(1'b1, 11'h0f0, 8'h5a);
        repeat (5) @(posedge CLK);
        @(negedge CLK);
        compare(32'(busy), 32'd1, "busy during request");
        issue(1'b1, b, 8'h11);
        issue(1'b0, b, 8'h00);
        wait_ack();
        repeat (40) @(posedge CLK);
        @(negedge CLK);
        compare(32'(busy), 32'd0, "busy after dropped strobes");
        read_byte(b);
        read_byte(11'h0f0);

        no_ack = 1'b1;
        write_byte(11'h733, 8'hc7);
        no_ack = 1'b0;
        read_byte(11'h733);

        repeat (20) @(posedge CLK);
        $display("checks done: %0d errors, %0d timeouts", err_cnt, timeout_cnt);
        if (err_cnt == 0 && timeout_cnt == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

/* src.f */
rtl/eeprom_pkg.sv
rtl/eeprom_req_regs.sv
rtl/eeprom_seq_ctrl.sv
rtl/eeprom_bit_engine.sv
rtl/eeprom_wr_top.sv
sim/eeprom_model.sv
sim/tb_eeprom_wr.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_eeprom_wr
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
LFLAGS    ?= --lint-only --timing
PASS_MSG  ?= Regression passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
